// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = led_matrix_tb
FILELIST  = led_matrix.f
OBJ_DIR   = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
run: $(BIN)
	@./$(BIN) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/frame_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_buffer import led_matrix_pkg::*; #(
    parameter int PIXEL_WIDTH = 64,
    parameter int PIXEL_HEIGHT = 32,
    localparam int BANK_DEPTH = PIXEL_WIDTH * (PIXEL_HEIGHT / 2),
    localparam int ADDR_W = $clog2(PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL),
    localparam int RD_W = $clog2(BANK_DEPTH)
) (
    input  wire logic              clk_in,
    input  wire logic              wr_en,
    input  wire logic [ADDR_W-1:0] wr_addr,
    input  wire logic [7:0]        wr_data,
    input  wire logic [RD_W-1:0]   rd_addr,
    output pixel_pair_t            rd_data
);

    localparam logic [ADDR_W-2:0] BANK_BASE = (ADDR_W - 1)'(BANK_DEPTH);

    pixel_t mem [2][BANK_DEPTH];  // bank 0 upper half, bank 1 lower half

    logic [ADDR_W-2:0] pix_index;
    logic              bank_sel;
    logic [RD_W-1:0]   bank_index;

    assign pix_index  = wr_addr[ADDR_W-1:1];
    assign bank_sel   = pix_index >= BANK_BASE;
    assign bank_index = RD_W'(bank_sel ? pix_index - BANK_BASE : pix_index);

    // even address is the low byte of the pixel
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr[0]) mem[bank_sel][bank_index][15:8] <= wr_data;
            else mem[bank_sel][bank_index][7:0] <= wr_data;
        end
    end

    always_ff @(posedge clk_in) begin
        rd_data.top    <= mem[0][rd_addr];
        rd_data.bottom <= mem[1][rd_addr];
    end

endmodule

`default_nettype wire

// ==== design/frame_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_loader import led_matrix_pkg::*; #(
    parameter int PIXEL_WIDTH = 64,
    parameter int PIXEL_HEIGHT = 32,
    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL,
    localparam int ADDR_W = $clog2(FRAME_BYTES)
) (
    input  wire logic                         clk_in,
    input  wire logic                         rst_n,
    input  wire logic [7:0]                   rx_data,
    input  wire logic                         rx_valid,
    output logic                              wr_en,
    output logic      [ADDR_W-1:0]            wr_addr,
    output logic      [7:0]                   wr_data,
    output rgb_t                              rgb_enable,
    output logic      [BRIGHTNESS_LEVELS-1:0] plane_enable
);

    typedef enum logic [1:0] {LD_IDLE, LD_FRAME, LD_BRIGHTNESS, LD_RGB} loader_state_e;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_BYTES - 1);

    loader_state_e state;

    // every byte of a frame goes straight to port A
    assign wr_en   = (state == LD_FRAME) && rx_valid;
    assign wr_data = rx_data;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state        <= LD_IDLE;
            wr_addr      <= '0;
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else if (rx_valid) begin
            case (state)
                LD_IDLE: begin
                    wr_addr <= '0;
                    case (ctrl_cmd_e'(rx_data))
                        CMD_FRAME:      state <= LD_FRAME;
                        CMD_BRIGHTNESS: state <= LD_BRIGHTNESS;
                        CMD_RGB_ENABLE: state <= LD_RGB;
                        default:        state <= LD_IDLE;  // not a command so it is skipped
                    endcase
                end
                LD_FRAME: begin
                    wr_addr <= wr_addr + 1'b1;
                    if (wr_addr == LAST_ADDR) state <= LD_IDLE;
                end
                LD_BRIGHTNESS: begin
                    plane_enable <= rx_data[BRIGHTNESS_LEVELS-1:0];
                    state        <= LD_IDLE;
                end
                LD_RGB: begin
                    rgb_enable <= rgb_t'(rx_data[2:0]);  // bit 0 blue, bit 2 red
                    state      <= LD_IDLE;
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    a_wr_addr_range: assert property (@(posedge clk_in) disable iff (!rst_n)
        wr_en |-> wr_addr <= LAST_ADDR);

endmodule

`default_nettype wire

// ==== design/led_matrix_pkg.sv ====
`default_nettype none

package led_matrix_pkg;

    parameter int BRIGHTNESS_LEVELS = 5;  // bit-planes per colour channel
    parameter int BYTES_PER_PIXEL = 2;
    parameter int ROW_ADDR_WIDTH = 4;     // A..D lines on the panel

    // one stored pixel, rgb555 with a spare top bit
    typedef struct packed {
        logic       unused;
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } pixel_t;

    // same column, upper and lower half of the panel
    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    // blue lands on bit 0
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    typedef struct packed {
        rgb_t                      rgb1;
        rgb_t                      rgb2;
        logic                      clk_pixel;
        logic                      row_latch;
        logic                      output_enable;  // active high, panel pin is inverted
        logic [ROW_ADDR_WIDTH-1:0] row_address;
    } panel_lines_t;

    typedef enum logic [7:0] {
        CMD_BRIGHTNESS = 8'h42,  // 'B' + plane mask byte
        CMD_RGB_ENABLE = 8'h43,  // 'C' + channel mask byte
        CMD_FRAME      = 8'h46   // 'F' + whole frame
    } ctrl_cmd_e;

    typedef logic [2:0] plane_t;

endpackage

`default_nettype wire

// ==== design/led_matrix_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_matrix_top import led_matrix_pkg::*; #(
    parameter int PIXEL_WIDTH = 64,
    parameter int PIXEL_HEIGHT = 32,
    parameter int CLK_TICKS_PER_BIT = 9,
    parameter int ON_UNIT = 32
) (
    input  wire logic   clk_in,
    input  wire logic   rst_n,
    input  wire logic   uart_rx_line,
    output panel_lines_t panel
);

    localparam int ADDR_W = $clog2(PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL);
    localparam int COL_W = $clog2(PIXEL_WIDTH);
    localparam int ROW_W = $clog2(PIXEL_HEIGHT / 2);
    localparam int RD_W = $clog2(PIXEL_WIDTH * (PIXEL_HEIGHT / 2));

    logic [7:0]                   rx_data;
    logic                         rx_valid;
    logic                         wr_en;
    logic [ADDR_W-1:0]            wr_addr;
    logic [7:0]                   wr_data;
    rgb_t                         rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] plane_enable;
    logic [RD_W-1:0]              rd_addr;
    pixel_pair_t                  rd_data;
    pixel_pair_t                  pixel_pair;
    logic                         load_strobe;
    logic [COL_W-1:0]             column;
    logic [ROW_W-1:0]             row;
    plane_t                       plane;
    logic                         clk_pixel;
    logic                         row_latch;
    logic                         output_enable;
    logic [ROW_ADDR_WIDTH-1:0]    row_address;
    rgb_t                         rgb1;  // upper half
    rgb_t                         rgb2;  // lower half

    uart_rx #(.CLK_TICKS_PER_BIT(CLK_TICKS_PER_BIT)) uart_rx_i (
        .clk_in(clk_in), .rst_n(rst_n), .rx_line(uart_rx_line),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    frame_loader #(.PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HEIGHT(PIXEL_HEIGHT)) frame_loader_i (
        .clk_in(clk_in), .rst_n(rst_n), .rx_data(rx_data), .rx_valid(rx_valid),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rgb_enable(rgb_enable), .plane_enable(plane_enable)
    );

    frame_buffer #(.PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HEIGHT(PIXEL_HEIGHT)) frame_buffer_i (
        .clk_in(clk_in), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    row_fetch #(.PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HEIGHT(PIXEL_HEIGHT)) row_fetch_i (
        .clk_in(clk_in), .rst_n(rst_n), .load_strobe(load_strobe),
        .column(column), .row(row), .rd_addr(rd_addr), .rd_data(rd_data),
        .pixel_pair(pixel_pair)
    );

    matrix_scan #(
        .PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HEIGHT(PIXEL_HEIGHT), .ON_UNIT(ON_UNIT)
    ) matrix_scan_i (
        .clk_in(clk_in), .rst_n(rst_n), .load_strobe(load_strobe),
        .column(column), .row(row), .plane(plane), .clk_pixel(clk_pixel),
        .row_latch(row_latch), .output_enable(output_enable), .row_address(row_address)
    );

    pixel_split px_top (
        .pixel(pixel_pair.top), .plane(plane), .rgb_enable(rgb_enable),
        .plane_enable(plane_enable), .rgb(rgb1)
    );

    pixel_split px_bottom (
        .pixel(pixel_pair.bottom), .plane(plane), .rgb_enable(rgb_enable),
        .plane_enable(plane_enable), .rgb(rgb2)
    );

    assign panel = '{
        rgb1:          rgb1,
        rgb2:          rgb2,
        clk_pixel:     clk_pixel,
        row_latch:     row_latch,
        output_enable: output_enable,
        row_address:   row_address
    };

endmodule

`default_nettype wire

// ==== design/matrix_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module matrix_scan import led_matrix_pkg::*; #(
    parameter int PIXEL_WIDTH = 64,
    parameter int PIXEL_HEIGHT = 32,
    parameter int ON_UNIT = 32,
    localparam int COL_W = $clog2(PIXEL_WIDTH),
    localparam int ROW_W = $clog2(PIXEL_HEIGHT / 2)
) (
    input  wire logic                      clk_in,
    input  wire logic                      rst_n,
    output logic                           load_strobe,
    output logic      [COL_W-1:0]          column,
    output logic      [ROW_W-1:0]          row,
    output plane_t                         plane,
    output logic                           clk_pixel,
    output logic                           row_latch,
    output logic                           output_enable,
    output logic      [ROW_ADDR_WIDTH-1:0] row_address
);

    typedef enum logic [2:0] {LOAD, WAIT, SHIFT, LATCH, DISPLAY, BLANK} scan_state_e;

    localparam int ON_W = $clog2((ON_UNIT << (BRIGHTNESS_LEVELS - 1)) + 1);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(PIXEL_WIDTH - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(PIXEL_HEIGHT / 2 - 1);
    localparam plane_t LAST_PLANE = plane_t'(BRIGHTNESS_LEVELS - 1);

    scan_state_e     state;
    logic [ON_W-1:0] timer;  // wait count up, on-time count down
    logic [ON_W-1:0] on_time;

    assign on_time = ON_W'(ON_UNIT) << plane;  // binary code modulation weight

    assign load_strobe   = state == LOAD;
    assign clk_pixel     = state == SHIFT;
    assign row_latch     = state == LATCH;
    assign output_enable = state == DISPLAY;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state       <= LOAD;
            timer       <= '0;
            column      <= '0;
            row         <= '0;
            plane       <= '0;
            row_address <= '0;
        end else begin
            case (state)
                LOAD: begin
                    timer <= '0;
                    state <= WAIT;
                end
                WAIT: begin
                    // two cycles for the pixel pair to arrive
                    if (timer == ON_W'(1)) state <= SHIFT;
                    else timer <= timer + 1'b1;
                end
                SHIFT: begin
                    if (column == LAST_COL) begin
                        column <= '0;
                        state  <= LATCH;
                    end else begin
                        column <= column + 1'b1;
                        state  <= LOAD;
                    end
                end
                LATCH: begin
                    row_address <= ROW_ADDR_WIDTH'(row);
                    timer       <= on_time - 1'b1;
                    state       <= DISPLAY;
                end
                DISPLAY: begin
                    if (timer == '0) state <= BLANK;
                    else timer <= timer - 1'b1;
                end
                BLANK: begin
                    state <= LOAD;
                    if (plane == LAST_PLANE) begin
                        plane <= '0;
                        row   <= (row == LAST_ROW) ? '0 : row + 1'b1;
                    end else plane <= plane + 1'b1;
                end
                default: state <= LOAD;
            endcase
        end
    end

    // latch first, then the display window opens on the next cycle
    a_latch_before_oe: assert property (@(posedge clk_in) disable iff (!rst_n)
        row_latch |-> !output_enable ##1 output_enable);

    a_no_shift_in_display: assert property (@(posedge clk_in) disable iff (!rst_n)
        state == DISPLAY |-> !clk_pixel);

endmodule

`default_nettype wire

// ==== design/pixel_split.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_split import led_matrix_pkg::*; (
    input  wire pixel_t                         pixel,
    input  wire plane_t                         plane,
    input  wire rgb_t                           rgb_enable,
    input  wire logic   [BRIGHTNESS_LEVELS-1:0] plane_enable,
    output rgb_t                                rgb
);

    logic plane_on;

    assign plane_on = plane_enable[plane];  // plane 0 is the lsb of each field

    assign rgb.red   = pixel.red[plane] & rgb_enable.red & plane_on;
    assign rgb.green = pixel.green[plane] & rgb_enable.green & plane_on;
    assign rgb.blue  = pixel.blue[plane] & rgb_enable.blue & plane_on;

endmodule

`default_nettype wire

// ==== design/row_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_fetch import led_matrix_pkg::*; #(
    parameter int PIXEL_WIDTH = 64,
    parameter int PIXEL_HEIGHT = 32,
    localparam int COL_W = $clog2(PIXEL_WIDTH),
    localparam int ROW_W = $clog2(PIXEL_HEIGHT / 2),
    localparam int RD_W = $clog2(PIXEL_WIDTH * (PIXEL_HEIGHT / 2))
) (
    input  wire logic             clk_in,
    input  wire logic             rst_n,
    input  wire logic             load_strobe,
    input  wire logic [COL_W-1:0] column,
    input  wire logic [ROW_W-1:0] row,
    output logic      [RD_W-1:0]  rd_addr,
    input  wire pixel_pair_t      rd_data,
    output pixel_pair_t           pixel_pair
);

    logic load_d;  // strobe lined up with the memory read latency

    // index inside a bank, both halves share it
    assign rd_addr = RD_W'(row) * RD_W'(PIXEL_WIDTH) + RD_W'(column);

    always_ff @(posedge clk_in) begin
        if (!rst_n) load_d <= 1'b0;
        else load_d <= load_strobe;
    end

    // held until the next column lands
    always_ff @(posedge clk_in) begin
        if (load_d) pixel_pair <= rd_data;
    end

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLK_TICKS_PER_BIT = 9
) (
    input  wire logic       clk_in,
    input  wire logic       rst_n,
    input  wire logic       rx_line,
    output logic      [7:0] rx_data,
    output logic            rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    localparam int TICK_W = $clog2(CLK_TICKS_PER_BIT + 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(CLK_TICKS_PER_BIT - 1);
    localparam logic [TICK_W-1:0] HALF_TICK = TICK_W'(CLK_TICKS_PER_BIT / 2 - 1);

    rx_state_e         state;
    logic [1:0]        sync;     // line is idle high
    logic              rx_bit;
    logic [TICK_W-1:0] tick;
    logic [2:0]        bit_cnt;

    assign rx_bit = sync[1];

    always_ff @(posedge clk_in) begin
        if (!rst_n) sync <= 2'b11;
        else sync <= {sync[0], rx_line};
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick     <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (!rx_bit) state <= RX_START;  // falling edge of start bit
                end
                RX_START: begin
                    if (tick == HALF_TICK) begin
                        tick    <= '0;
                        bit_cnt <= '0;
                        // still low at mid-bit, otherwise it was a glitch
                        state   <= rx_bit ? RX_IDLE : RX_DATA;
                    end else tick <= tick + 1'b1;
                end
                RX_DATA: begin
                    if (tick == LAST_TICK) begin
                        tick    <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end else tick <= tick + 1'b1;
                end
                RX_STOP: begin
                    if (tick == LAST_TICK) begin
                        rx_valid <= rx_bit;  // framing error drops the byte
                        state    <= RX_IDLE;
                    end else tick <= tick + 1'b1;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && tick == LAST_TICK) rx_data <= {rx_bit, rx_data[7:1]};
    end

endmodule

`default_nettype wire

// ==== led_matrix.f ====
design/led_matrix_pkg.sv
design/uart_rx.sv
design/frame_loader.sv
design/frame_buffer.sv
design/row_fetch.sv
design/matrix_scan.sv
design/pixel_split.sv
design/led_matrix_top.sv
verif/led_matrix_tb.sv

// ==== verif/led_matrix_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_matrix_tb import led_matrix_pkg::*; ();

    localparam int PIXEL_WIDTH = 8;
    localparam int PIXEL_HEIGHT = 4;
    localparam int HALF_HEIGHT = PIXEL_HEIGHT / 2;
    localparam int CLK_TICKS_PER_BIT = 4;
    localparam int ON_UNIT = 2;
    localparam int PLANES = 5;
    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * 2;
    localparam int LONGEST_ON = ON_UNIT << (PLANES - 1);
    localparam int WAIT_LIMIT = 1000;  // cycles, far above one full scan

    logic         clk_in;
    logic         rst_n;
    logic         uart_rx_line;
    panel_lines_t panel;

    logic [7:0] frame_model [FRAME_BYTES];  // byte image as sent over the uart
    logic [2:0] model_rgb_enable;           // {red, green, blue}
    logic [4:0] model_plane_enable;
    integer     seed;
    int         value_errors;
    int         timeout_errors;

    led_matrix_top #(
        .PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .CLK_TICKS_PER_BIT(CLK_TICKS_PER_BIT), .ON_UNIT(ON_UNIT)
    ) led_matrix_top_i (
        .clk_in(clk_in), .rst_n(rst_n), .uart_rx_line(uart_rx_line), .panel(panel)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // expected colour bits of one pixel for one plane
    function automatic logic [2:0] model_rgb(input int pix_index, input int plane);
        logic [15:0] pix;
        logic [2:0]  bits;
        pix  = {frame_model[2 * pix_index + 1], frame_model[2 * pix_index]};  // low byte first
        bits = {pix[10 + plane], pix[5 + plane], pix[plane]};
        return bits & model_rgb_enable & {3{model_plane_enable[plane]}};
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int got);
        $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
        value_errors++;
    endtask

    task automatic note_timeout(input string what);
        $display("timeout at %0t: no %s seen within %0d cycles", $time, what, WAIT_LIMIT);
        timeout_errors++;
    endtask

    // 8N1, lsb first, one idle bit time after the stop bit
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] line_bits;
        line_bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx_line = line_bits[i];
            repeat (CLK_TICKS_PER_BIT) @(negedge clk_in);
        end
        repeat (CLK_TICKS_PER_BIT) @(negedge clk_in);
    endtask

    task automatic send_frame;
        for (int i = 0; i < FRAME_BYTES; i++) frame_model[i] = 8'($random(seed));
        send_byte(CMD_FRAME);
        for (int i = 0; i < FRAME_BYTES; i++) send_byte(frame_model[i]);
    endtask

    // returns in the blank cycle after the last row at plane 4,
    // so the next row period is row 0, plane 0
    task automatic wait_row_start;
        int cycles;
        int on_len;
        if (timeout_errors != 0) return;
        cycles = 0;
        on_len = 0;
        while (cycles < WAIT_LIMIT) begin
            @(negedge clk_in);
            cycles++;
            if (panel.output_enable) on_len++;
            else if (on_len != 0) begin
                if (on_len == LONGEST_ON && panel.row_address == 4'(HALF_HEIGHT - 1)) return;
                on_len = 0;
            end
        end
        note_timeout("end of the last row period");
    endtask

    // one full scan: pixel data, pulse counts, row address and on-times
    task automatic compare_scan;
        int         row;
        int         plane;
        int         col;
        int         on_len;
        int         cycles;
        logic [2:0] exp_top;
        logic [2:0] exp_bottom;
        if (timeout_errors != 0) return;
        for (int period = 0; period < HALF_HEIGHT * PLANES; period++) begin
            row    = period / PLANES;
            plane  = period % PLANES;
            col    = 0;
            cycles = 0;
            do begin
                @(negedge clk_in);
                cycles++;
                if (panel.clk_pixel && col < PIXEL_WIDTH) begin
                    exp_top    = model_rgb(row * PIXEL_WIDTH + col, plane);
                    exp_bottom = model_rgb((row + HALF_HEIGHT) * PIXEL_WIDTH + col, plane);
                    if (panel.rgb1 != exp_top)
                        report_mismatch("rgb1", int'(exp_top), int'(panel.rgb1));
                    if (panel.rgb2 != exp_bottom)
                        report_mismatch("rgb2", int'(exp_bottom), int'(panel.rgb2));
                end
                if (panel.clk_pixel) col++;
            end while (!panel.row_latch && cycles < WAIT_LIMIT);
            if (!panel.row_latch) begin
                note_timeout("row_latch");
                return;
            end
            if (col != PIXEL_WIDTH) report_mismatch("clk_pixel count", PIXEL_WIDTH, col);
            on_len = 0;
            cycles = 0;
            @(negedge clk_in);
            while (panel.output_enable && cycles < WAIT_LIMIT) begin
                on_len++;
                // row_address takes the row on the latch edge
                if (panel.row_address != 4'(row))
                    report_mismatch("row_address", row, int'(panel.row_address));
                @(negedge clk_in);
                cycles++;
            end
            if (panel.output_enable) begin
                note_timeout("end of output_enable");
                return;
            end
            if (on_len != (ON_UNIT << plane))
                report_mismatch("output_enable length", ON_UNIT << plane, on_len);
        end
    endtask

    task automatic reset_outputs_idle;
        int cycles;
        repeat (4) begin
            @(negedge clk_in);
            if (panel.clk_pixel != 1'b0) report_mismatch("clk_pixel", 0, 1);
            if (panel.row_latch != 1'b0) report_mismatch("row_latch", 0, 1);
            if (panel.output_enable != 1'b0) report_mismatch("output_enable", 0, 1);
        end
        rst_n  = 1'b1;
        cycles = 0;
        while (!panel.clk_pixel && cycles < WAIT_LIMIT) begin
            if (panel.row_latch != 1'b0) report_mismatch("row_latch", 0, 1);
            if (panel.output_enable != 1'b0) report_mismatch("output_enable", 0, 1);
            if (panel.row_address != 4'd0)
                report_mismatch("row_address", 0, int'(panel.row_address));
            @(negedge clk_in);
            cycles++;
        end
        if (!panel.clk_pixel) note_timeout("first clk_pixel");
    endtask

    task automatic full_frame_display;
        send_frame();
        wait_row_start();
        compare_scan();
    endtask

    task automatic red_channel_only;
        send_byte(CMD_RGB_ENABLE);
        send_byte(8'h04);  // bit 2 is red
        model_rgb_enable = 3'b100;
        wait_row_start();
        compare_scan();
    endtask

    task automatic lowest_plane_only;
        send_byte(CMD_RGB_ENABLE);
        send_byte(8'h07);
        model_rgb_enable = 3'b111;
        send_byte(CMD_BRIGHTNESS);
        send_byte(8'h01);
        model_plane_enable = 5'b00001;
        wait_row_start();
        compare_scan();
    endtask

    task automatic unknown_byte_skipped;
        send_byte(CMD_BRIGHTNESS);
        send_byte(8'h1f);
        model_plane_enable = 5'b11111;
        send_byte(8'h17);  // no such opcode
        send_byte(8'ha5);
        full_frame_display();
    endtask

    initial begin
        seed               = 53729;
        value_errors       = 0;
        timeout_errors     = 0;
        model_rgb_enable   = 3'b111;
        model_plane_enable = 5'b11111;
        rst_n              = 1'b0;
        uart_rx_line       = 1'b1;  // uart idle level
        reset_outputs_idle();
        full_frame_display();
        red_channel_only();
        lowest_plane_only();
        unknown_byte_skipped();
        $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
